/* rtl/if_pkg.sv */
/* Shared types, packed structs and fixed encodings
   used across the instruction fetch stage */
package if_pkg;

  //////////////////////////////
  // Base types
  //////////////////////////////

  // Byte address on the instruction side
  typedef logic [31:0] addr_t;

  // Fetched instruction, always 32 bit wide
  typedef logic [31:0] instr_t;

  // Interrupt number used for vectoring
  typedef logic [4:0] irq_id_t;

  // Redirect source selected by the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Controller to IF
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    irq_id_t irq_id;
    logic    halt_if;
    logic    kill_if;
  } if_ctrl_t;

  // Candidate redirect addresses
  typedef struct packed {
    addr_t boot_addr;
    addr_t jump_target;
    addr_t branch_target;
    addr_t mepc;
    addr_t mtvec_base;
  } if_targets_t;

  // AXI4-Lite read address and read data
  typedef struct packed {
    addr_t      araddr;
    logic [2:0] arprot;
  } axi_ar_t;

  typedef struct packed {
    instr_t     rdata;
    logic [1:0] rresp;
  } axi_r_t;

  // One prefetch queue entry
  typedef struct packed {
    addr_t  pc;
    instr_t instr;
    logic   bus_err;
  } fetch_word_t;

  // IF/ID pipeline register
  typedef struct packed {
    logic   valid;
    addr_t  pc;
    instr_t instr;
    logic   dummy;
    logic   bus_err;
    logic   abort;
  } if_id_pipe_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Privileged instruction access
  localparam logic [2:0] IF_ARPROT     = 3'b101;
  localparam logic [6:0] DUMMY_OPCODE  = 7'b0010011;
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
  // Byte distance between vectored interrupt entries
  localparam addr_t      IRQ_STRIDE    = 32'd4;

endpackage

/* rtl/prefetch_unit.sv */
/* Redirect address selection, AXI4-Lite read master with request credit,
   stale beat discard after a flush, and the prefetch queue */
module prefetch_unit #(
  parameter int unsigned FETCH_DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::if_ctrl_t    ctrl_i,
  input  if_pkg::if_targets_t targets_i,
  input  logic                fetch_ready_i,
  output logic                fetch_valid_o,
  output if_pkg::fetch_word_t fetch_o,
  output logic                busy_o,
  output logic                arvalid_o,
  input  logic                arready_i,
  output if_pkg::axi_ar_t     ar_o,
  input  logic                rvalid_i,
  output logic                rready_o,
  input  if_pkg::axi_r_t      r_i
);

  import if_pkg::*;

  localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int unsigned PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
  // Uncompressed only, so the PC always steps by a word
  localparam addr_t       PC_STEP = 32'd4;

  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [PTR_W-1:0] ptr_t;

  addr_t          redirect_addr;
  logic           flush;
  logic           fetch_en_q;
  // Address of the next request to raise
  addr_t          next_addr_q;
  // PC of the next beat that is kept
  addr_t          resp_pc_q;
  logic           arvalid_q;
  addr_t          ar_addr_q;
  // Requests raised on AR and not yet answered on R
  cnt_t           req_cnt_q;
  // Stale beats still to be dropped
  cnt_t           discard_cnt_q;
  cnt_t           q_cnt_q;
  ptr_t           wr_ptr_q;
  ptr_t           rd_ptr_q;
  fetch_word_t    queue_mem [FETCH_DEPTH];
  logic [CNT_W:0] reserved;
  logic           credit;
  logic           new_req;
  logic           r_hs;
  logic           keep_beat;
  logic           pop;

  //////////////////////////////
  // Redirect address
  //////////////////////////////

  always_comb begin
    unique case (ctrl_i.pc_mux)
      PC_BOOT:     redirect_addr = {targets_i.boot_addr[31:2], 2'b00};
      PC_JUMP:     redirect_addr = targets_i.jump_target;
      PC_BRANCH:   redirect_addr = targets_i.branch_target;
      PC_MRET:     redirect_addr = targets_i.mepc;
      PC_TRAP_EXC: redirect_addr = targets_i.mtvec_base;
      // Vectored entry per interrupt number
      PC_TRAP_IRQ: redirect_addr = targets_i.mtvec_base + (addr_t'(ctrl_i.irq_id) * IRQ_STRIDE);
      default:     redirect_addr = {targets_i.boot_addr[31:2], 2'b00};
    endcase
  end

  // Kill empties the queue as well, but keeps the address stream
  assign flush = ctrl_i.pc_set || ctrl_i.kill_if;

  //////////////////////////////
  // Request credit
  //////////////////////////////

  // A slot is reserved when AR is raised, so R never has to stall
  assign rready_o  = 1'b1;
  assign r_hs      = rvalid_i && rready_o;
  assign reserved  = {1'b0, req_cnt_q} + {1'b0, q_cnt_q};
  assign credit    = reserved < (CNT_W + 1)'(FETCH_DEPTH);
  // Raise a new request only when AR is free next cycle
  assign new_req   = fetch_en_q && !flush && credit && (!arvalid_q || arready_i);
  // Beats in the flush cycle are stale by definition
  assign keep_beat = r_hs && !flush && (discard_cnt_q == '0);
  assign pop       = fetch_valid_o && fetch_ready_i && !flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q  <= 1'b0;
      arvalid_q   <= 1'b0;
      next_addr_q <= '0;
      resp_pc_q   <= '0;
    end else begin
      // Nothing is fetched before the first redirect
      if (ctrl_i.pc_set) begin
        fetch_en_q <= 1'b1;
      end
      // AR stays up until accepted
      arvalid_q <= (arvalid_q && !arready_i) || new_req;
      if (ctrl_i.pc_set) begin
        next_addr_q <= redirect_addr;
        resp_pc_q   <= redirect_addr;
      end else begin
        if (new_req) begin
          next_addr_q <= next_addr_q + PC_STEP;
        end
        // After a kill the first kept beat is the next unrequested address
        if (ctrl_i.kill_if) begin
          resp_pc_q <= next_addr_q;
        end else if (keep_beat) begin
          resp_pc_q <= resp_pc_q + PC_STEP;
        end
      end
    end
  end

  // Address payload, held while arvalid waits for arready
  always_ff @(posedge clk) begin
    if (new_req) begin
      ar_addr_q <= next_addr_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_cnt_q     <= '0;
      discard_cnt_q <= '0;
    end else begin
      req_cnt_q <= req_cnt_q + cnt_t'(new_req) - cnt_t'(r_hs);
      // Everything still in flight turns stale on a flush
      if (flush) begin
        discard_cnt_q <= req_cnt_q - cnt_t'(r_hs);
      end else if (r_hs && (discard_cnt_q != '0)) begin
        discard_cnt_q <= discard_cnt_q - 1'b1;
      end
    end
  end

  //////////////////////////////
  // Prefetch queue
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      q_cnt_q  <= '0;
    end else if (flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      q_cnt_q  <= '0;
    end else begin
      if (keep_beat) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(FETCH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      q_cnt_q <= q_cnt_q + cnt_t'(keep_beat) - cnt_t'(pop);
    end
  end

  // Tag each kept beat with its PC, any non-OKAY response is a bus error
  always_ff @(posedge clk) begin
    if (keep_beat) begin
      queue_mem[wr_ptr_q] <= '{pc: resp_pc_q,
                               instr: r_i.rdata,
                               bus_err: (r_i.rresp != AXI_RESP_OKAY)};
    end
  end

  assign fetch_valid_o = (q_cnt_q != '0);
  assign fetch_o       = queue_mem[rd_ptr_q];
  assign busy_o        = (req_cnt_q != '0);
  assign arvalid_o     = arvalid_q;
  assign ar_o          = '{araddr: ar_addr_q, arprot: IF_ARPROT};

endmodule

/* rtl/dummy_instr_gen.sv */
/* Filler instruction generator, an LFSR for the
   operand fields and an issue counter for the schedule */
module dummy_instr_gen #(
  parameter int unsigned DUMMY_EVERY = 4
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           dummy_en_i,
  input  logic           issued_i,
  input  logic           issued_dummy_i,
  output logic           dummy_insert_o,
  output if_pkg::instr_t dummy_word_o
);

  import if_pkg::*;

  localparam int unsigned CNT_W = $clog2(DUMMY_EVERY + 1);
  // x^32 + x^22 + x^2 + x + 1, right shifting Galois form
  localparam logic [31:0] LFSR_POLY = 32'h8020_0003;
  // Any nonzero start value
  localparam logic [31:0] LFSR_SEED = 32'h1f3a_9c55;

  logic [31:0]      lfsr_q;
  logic [CNT_W-1:0] issue_cnt_q;
  logic             cnt_full;
  logic             dummy_done;
  logic [2:0]       funct3;

  assign dummy_done = issued_i && issued_dummy_i;

  //////////////////////////////
  // Issue counter
  //////////////////////////////

  assign cnt_full       = (issue_cnt_q == CNT_W'(DUMMY_EVERY));
  assign dummy_insert_o = cnt_full && dummy_en_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_cnt_q <= '0;
    end else if (!dummy_en_i || dummy_done) begin
      // Restart the interval after each filler, or while disabled
      issue_cnt_q <= '0;
    end else if (issued_i && !cnt_full) begin
      issue_cnt_q <= issue_cnt_q + 1'b1;
    end
  end

  //////////////////////////////
  // LFSR
  //////////////////////////////

  // One step per issued filler
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= LFSR_SEED;
    end else if (dummy_done) begin
      lfsr_q <= {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_POLY : 32'h0);
    end
  end

  // Only ADDI, SLTI, XORI and ORI
  // Shift encodings would constrain the immediate
  assign funct3 = {lfsr_q[14:13], 1'b0};

  // rd is x0, so the filler never changes architectural state
  assign dummy_word_o = {lfsr_q[31:20], lfsr_q[19:15], funct3, 5'b00000, DUMMY_OPCODE};

endmodule

/* rtl/if_issue.sv */
/* Source selection between fetched word and filler,
   and the IF/ID pipeline register */
module if_issue (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::if_ctrl_t    ctrl_i,
  input  logic                id_ready_i,
  input  logic                fetch_valid_i,
  input  if_pkg::fetch_word_t fetch_i,
  output logic                fetch_ready_o,
  input  logic                dummy_insert_i,
  input  if_pkg::instr_t      dummy_word_i,
  output logic                issued_o,
  output logic                issued_dummy_o,
  output if_pkg::if_id_pipe_t if_id_pipe_o
);

  import if_pkg::*;

  logic        candidate;
  logic        blocked;
  logic        issue;
  if_id_pipe_t pipe_d;

  // A filler borrows the PC of the waiting word, so a word must be present
  assign candidate = fetch_valid_i;
  assign blocked   = ctrl_i.halt_if || ctrl_i.kill_if;
  assign issue     = id_ready_i && candidate && !blocked;

  assign issued_o       = issue;
  assign issued_dummy_o = issue && dummy_insert_i;

  // Pop only for a real issue, or drop the head on kill
  assign fetch_ready_o = (issue && !dummy_insert_i) || ctrl_i.kill_if;

  //////////////////////////////
  // Next entry
  //////////////////////////////

  always_comb begin
    pipe_d       = '0;
    pipe_d.valid = 1'b1;
    pipe_d.pc    = fetch_i.pc;
    if (dummy_insert_i) begin
      // Filler has priority and never aborts
      pipe_d.instr   = dummy_word_i;
      pipe_d.dummy   = 1'b1;
      pipe_d.bus_err = 1'b0;
      pipe_d.abort   = 1'b0;
    end else begin
      pipe_d.instr   = fetch_i.instr;
      pipe_d.dummy   = 1'b0;
      pipe_d.bus_err = fetch_i.bus_err;
      // Bus error turns into an abort in later stages
      pipe_d.abort   = fetch_i.bus_err;
    end
  end

  //////////////////////////////
  // IF/ID register
  //////////////////////////////

  // Frozen while ID applies back-pressure
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o <= '0;
    end else if (id_ready_i) begin
      if (issue) begin
        if_id_pipe_o <= pipe_d;
      end else begin
        // Bubble on halt, kill or empty queue
        if_id_pipe_o.valid <= 1'b0;
      end
    end
  end

endmodule

/* rtl/if_stage.sv */
/* Instruction fetch stage top level, prefetch unit,
   filler generator and issue stage */
module if_stage #(
  parameter int unsigned FETCH_DEPTH = 2,
  parameter int unsigned DUMMY_EVERY = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  // Controller
  input  if_pkg::if_ctrl_t    ctrl_i,
  input  if_pkg::if_targets_t targets_i,
  input  logic                dummy_en_i,
  // ID side
  input  logic                id_ready_i,
  output if_pkg::if_id_pipe_t if_id_pipe_o,
  output logic                if_busy_o,
  // AXI4-Lite read channels
  output logic                arvalid_o,
  input  logic                arready_i,
  output if_pkg::axi_ar_t     ar_o,
  input  logic                rvalid_i,
  output logic                rready_o,
  input  if_pkg::axi_r_t      r_i
);

  import if_pkg::*;

  // Queue head towards issue
  logic        fetch_valid;
  logic        fetch_ready;
  fetch_word_t fetch_word;
  // Filler handshake
  logic        dummy_insert;
  instr_t      dummy_word;
  logic        issued;
  logic        issued_dummy;

  prefetch_unit #(
    .FETCH_DEPTH (FETCH_DEPTH)
  ) prefetch_unit_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .targets_i     (targets_i),
    .fetch_ready_i (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_o       (fetch_word),
    .busy_o        (if_busy_o),
    .arvalid_o     (arvalid_o),
    .arready_i     (arready_i),
    .ar_o          (ar_o),
    .rvalid_i      (rvalid_i),
    .rready_o      (rready_o),
    .r_i           (r_i)
  );

  dummy_instr_gen #(
    .DUMMY_EVERY (DUMMY_EVERY)
  ) dummy_instr_gen_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .dummy_en_i     (dummy_en_i),
    .issued_i       (issued),
    .issued_dummy_i (issued_dummy),
    .dummy_insert_o (dummy_insert),
    .dummy_word_o   (dummy_word)
  );

  if_issue if_issue_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_i         (ctrl_i),
    .id_ready_i     (id_ready_i),
    .fetch_valid_i  (fetch_valid),
    .fetch_i        (fetch_word),
    .fetch_ready_o  (fetch_ready),
    .dummy_insert_i (dummy_insert),
    .dummy_word_i   (dummy_word),
    .issued_o       (issued),
    .issued_dummy_o (issued_dummy),
    .if_id_pipe_o   (if_id_pipe_o)
  );

endmodule

/* sim/if_stage_asserts.sv */
/* Bound checker for the fetch stage, reference PC tracking,
   filler spacing and concurrent assertions on pipe and bus */
module if_stage_asserts #(
  parameter int unsigned FETCH_DEPTH = 2,
  parameter int unsigned DUMMY_EVERY = 4
) (
  // Port names mirror the bound module, so outputs there are inputs here
  input logic                clk,
  input logic                rst_n,
  input if_pkg::if_ctrl_t    ctrl_i,
  input if_pkg::if_targets_t targets_i,
  input logic                dummy_en_i,
  input logic                id_ready_i,
  input if_pkg::if_id_pipe_t if_id_pipe_o,
  input logic                if_busy_o,
  input logic                arvalid_o,
  input logic                arready_i,
  input if_pkg::axi_ar_t     ar_o,
  input logic                rvalid_i,
  input logic                rready_o
);

  import if_pkg::*;

  // Memory model answers every read with its address XOR this value
  localparam instr_t MEM_PATTERN = 32'h3c5a_96e1;

  int unsigned error_cnt = 0;
  addr_t       redirect_pc;
  addr_t       exp_pc_q;
  logic        exp_known_q;
  addr_t       tgt_q;
  logic        redir_q;
  logic        kill_q;
  logic        loaded_q;
  logic        en_q;
  logic        started_q;
  // Fetched entries since the last filler
  int unsigned real_cnt_q;
  // Accepted AR minus transferred R beats
  int unsigned out_cnt_q;
  logic        new_entry;
  logic        new_real;
  logic        new_dummy;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  always_comb begin
    case (ctrl_i.pc_mux)
      PC_BOOT:     redirect_pc = targets_i.boot_addr & ~32'h3;
      PC_JUMP:     redirect_pc = targets_i.jump_target;
      PC_BRANCH:   redirect_pc = targets_i.branch_target;
      PC_MRET:     redirect_pc = targets_i.mepc;
      PC_TRAP_EXC: redirect_pc = targets_i.mtvec_base;
      // One word per interrupt number
      PC_TRAP_IRQ: redirect_pc = targets_i.mtvec_base + {25'd0, ctrl_i.irq_id, 2'b00};
      default:     redirect_pc = '0;
    endcase
  end

  // Entry visible now was loaded at the last edge
  assign new_entry = loaded_q && if_id_pipe_o.valid;
  assign new_real  = new_entry && !if_id_pipe_o.dummy;
  assign new_dummy = new_entry && if_id_pipe_o.dummy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc_q    <= '0;
      exp_known_q <= 1'b0;
      tgt_q       <= '0;
      redir_q     <= 1'b0;
      kill_q      <= 1'b0;
      loaded_q    <= 1'b0;
      en_q        <= 1'b0;
      started_q   <= 1'b0;
      real_cnt_q  <= 0;
      out_cnt_q   <= 0;
    end else begin
      loaded_q  <= id_ready_i;
      en_q      <= dummy_en_i;
      redir_q   <= ctrl_i.pc_set;
      kill_q    <= ctrl_i.kill_if;
      tgt_q     <= redirect_pc;
      out_cnt_q <= out_cnt_q + 32'(arvalid_o && arready_i) - 32'(rvalid_i && rready_o);
      if (ctrl_i.pc_set) begin
        started_q <= 1'b1;
      end
      // Redirect applies after the entry that issued in its own cycle
      if (redir_q) begin
        exp_pc_q    <= tgt_q;
        exp_known_q <= 1'b1;
      end else if (kill_q) begin
        exp_known_q <= 1'b0;
      end else if (new_real) begin
        exp_pc_q    <= if_id_pipe_o.pc + 32'd4;
        exp_known_q <= 1'b1;
      end
      if (!en_q || new_dummy) begin
        real_cnt_q <= 0;
      end else if (new_real) begin
        real_cnt_q <= real_cnt_q + 1;
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  pc_sequence: assert property (@(posedge clk) disable iff (!rst_n)
    (new_real && exp_known_q) |-> (if_id_pipe_o.pc == exp_pc_q)) else begin
    error_cnt++;
    $error("ERROR if_id_pipe_o.pc exp %h got %h", $sampled(exp_pc_q), $sampled(if_id_pipe_o.pc));
  end

  fetched_data: assert property (@(posedge clk) disable iff (!rst_n)
    new_real |-> ((if_id_pipe_o.instr == (if_id_pipe_o.pc ^ MEM_PATTERN)) &&
                  (if_id_pipe_o.bus_err == if_id_pipe_o.pc[31]) &&
                  (if_id_pipe_o.abort == if_id_pipe_o.pc[31]))) else begin
    error_cnt++;
    $error("ERROR if_id_pipe_o pc %h instr %h bus_err %h abort %h", $sampled(if_id_pipe_o.pc),
           $sampled(if_id_pipe_o.instr), $sampled(if_id_pipe_o.bus_err),
           $sampled(if_id_pipe_o.abort));
  end

  // Harmless OP-IMM to x0, only when enabled and only after a full interval
  dummy_format: assert property (@(posedge clk) disable iff (!rst_n)
    new_dummy |-> (en_q && (real_cnt_q == DUMMY_EVERY) && !if_id_pipe_o.abort &&
                   (if_id_pipe_o.instr[6:0] == DUMMY_OPCODE) &&
                   (if_id_pipe_o.instr[11:7] == 5'd0))) else begin
    error_cnt++;
    $error("ERROR dummy instr %h abort %h real_cnt %h dummy_en %h", $sampled(if_id_pipe_o.instr),
           $sampled(if_id_pipe_o.abort), $sampled(real_cnt_q), $sampled(en_q));
  end

  dummy_due: assert property (@(posedge clk) disable iff (!rst_n)
    (new_real && en_q) |-> (real_cnt_q < DUMMY_EVERY)) else begin
    error_cnt++;
    $error("ERROR missing dummy, real_cnt %h", $sampled(real_cnt_q));
  end

  pipe_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $past(!id_ready_i) |-> $stable(if_id_pipe_o)) else begin
    error_cnt++;
    $error("ERROR if_id_pipe_o changed under stall, was %h now %h",
           $past(if_id_pipe_o), $sampled(if_id_pipe_o));
  end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $past(arvalid_o && !arready_i) |-> (arvalid_o && $stable(ar_o))) else begin
    error_cnt++;
    $error("ERROR ar_o dropped or changed, was %h now %h arvalid_o %h",
           $past(ar_o), $sampled(ar_o), $sampled(arvalid_o));
  end

  // R never stalls and every read carries the instruction access protection
  bus_outputs: assert property (@(posedge clk) disable iff (!rst_n)
    rready_o && (!arvalid_o || (ar_o.arprot == IF_ARPROT))) else begin
    error_cnt++;
    $error("ERROR rready_o %h ar_o.arprot %h arvalid_o %h",
           $sampled(rready_o), $sampled(ar_o.arprot), $sampled(arvalid_o));
  end

  // Busy covers every accepted read still waiting for its beat
  busy_open_reads: assert property (@(posedge clk) disable iff (!rst_n)
    (out_cnt_q != 0) |-> if_busy_o) else begin
    error_cnt++;
    $error("ERROR if_busy_o %h with %h reads outstanding",
           $sampled(if_busy_o), $sampled(out_cnt_q));
  end

  outstanding_limit: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= FETCH_DEPTH) else begin
    error_cnt++;
    $error("ERROR outstanding reads %h above depth %h", $sampled(out_cnt_q), FETCH_DEPTH);
  end

  idle_before_start: assert property (@(posedge clk) disable iff (!rst_n)
    !started_q |-> (!arvalid_o && !if_busy_o && !if_id_pipe_o.valid)) else begin
    error_cnt++;
    $error("ERROR activity before first redirect, arvalid_o %h if_busy_o %h valid %h",
           $sampled(arvalid_o), $sampled(if_busy_o), $sampled(if_id_pipe_o.valid));
  end

  halt_kill_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    $past(id_ready_i && (ctrl_i.halt_if || ctrl_i.kill_if)) |-> !if_id_pipe_o.valid) else begin
    error_cnt++;
    $error("ERROR if_id_pipe_o.valid %h after halt or kill", $sampled(if_id_pipe_o.valid));
  end

endmodule

/* sim/tb_if_stage.sv */
/* Testbench for the fetch stage, clock and reset, AXI4-Lite memory
   model, random back-pressure, redirect stimulus and timeout */
module tb_if_stage;

  import if_pkg::*;

  localparam int unsigned FETCH_DEPTH    = 2;
  localparam int unsigned DUMMY_EVERY    = 4;
  localparam int unsigned RESET_CYCLES   = 10;
  localparam int unsigned TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] SEED           = 32'h5e57_1dd0;

  logic        clk;
  logic        rst_n;
  if_ctrl_t    ctrl;
  if_targets_t targets;
  logic        dummy_en;
  logic        id_ready;
  if_id_pipe_t pipe;
  logic        busy;
  logic        arvalid;
  logic        arready;
  axi_ar_t     ar;
  logic        rvalid;
  logic        rready;
  axi_r_t      r;
  instr_t      mem_pattern;
  int unsigned cycle_cnt;
  int unsigned real_seen;
  int unsigned dummy_seen;
  logic        ld_q;
  // Accepted reads waiting for their answer
  addr_t       pend_addr [$];
  int unsigned pend_due [$];

  if_stage #(
    .FETCH_DEPTH (FETCH_DEPTH),
    .DUMMY_EVERY (DUMMY_EVERY)
  ) if_stage_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl),
    .targets_i    (targets),
    .dummy_en_i   (dummy_en),
    .id_ready_i   (id_ready),
    .if_id_pipe_o (pipe),
    .if_busy_o    (busy),
    .arvalid_o    (arvalid),
    .arready_i    (arready),
    .ar_o         (ar),
    .rvalid_i     (rvalid),
    .rready_o     (rready),
    .r_i          (r)
  );

  bind if_stage if_stage_asserts #(
    .FETCH_DEPTH (FETCH_DEPTH),
    .DUMMY_EVERY (DUMMY_EVERY)
  ) if_stage_asserts_inst (.*);

  // Data pattern shared with the bound checker
  assign mem_pattern = if_stage_inst.if_stage_asserts_inst.MEM_PATTERN;

  always #10 clk = ~clk;

  //////////////////////////////
  // Memory model and ID side
  //////////////////////////////

  always @(posedge clk) begin
    addr_t rd_addr;
    if (rst_n) begin
      if (arvalid && arready) begin
        pend_addr.push_back(ar.araddr);
        pend_due.push_back(cycle_cnt + $urandom_range(1, 3));
      end
      if (!rvalid || rready) begin
        if ((pend_addr.size() != 0) && (pend_due[0] <= cycle_cnt)) begin
          rd_addr = pend_addr.pop_front();
          void'(pend_due.pop_front());
          rvalid <= 1'b1;
          // Upper half of the map is an error region
          r <= '{rdata: rd_addr ^ mem_pattern, rresp: rd_addr[31] ? 2'b10 : AXI_RESP_OKAY};
        end else begin
          rvalid <= 1'b0;
        end
      end
      arready  <= ($urandom_range(0, 3) != 0);
      id_ready <= ($urandom_range(0, 4) != 0);
    end
  end

  // Entries loaded into the IF/ID register
  always @(posedge clk) begin
    ld_q <= id_ready && rst_n;
    if (ld_q && pipe.valid) begin
      if (pipe.dummy) begin
        dummy_seen <= dummy_seen + 1;
      end else begin
        real_seen <= real_seen + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, fetched words stopped arriving", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic redirect(input pc_mux_e mux, input irq_id_t irq);
    @(posedge clk);
    ctrl.pc_set <= 1'b1;
    ctrl.pc_mux <= mux;
    ctrl.irq_id <= irq;
    @(posedge clk);
    ctrl.pc_set <= 1'b0;
  endtask

  // Returns once n more fetched words reached the pipe
  task automatic wait_entries(input int unsigned n);
    int unsigned goal;
    goal = real_seen + n;
    while (real_seen < goal) begin
      @(posedge clk);
    end
  endtask

  task automatic hold_stage(input int unsigned cycles);
    @(posedge clk);
    ctrl.halt_if <= 1'b1;
    repeat (cycles) @(posedge clk);
    ctrl.halt_if <= 1'b0;
  endtask

  task automatic kill_stage;
    @(posedge clk);
    ctrl.kill_if <= 1'b1;
    @(posedge clk);
    ctrl.kill_if <= 1'b0;
  endtask

  initial begin
    int unsigned errors;
    void'($urandom(SEED));
    clk        = 1'b0;
    rst_n      = 1'b0;
    ctrl       = '0;
    targets    = '{boot_addr: 32'h0000_1002, jump_target: 32'h0000_2000,
                   branch_target: 32'h0000_3104, mepc: 32'h0000_4008,
                   mtvec_base: 32'h0000_5000};
    dummy_en   = 1'b0;
    id_ready   = 1'b0;
    arready    = 1'b0;
    rvalid     = 1'b0;
    r          = '0;
    cycle_cnt  = 0;
    real_seen  = 0;
    dummy_seen = 0;
    ld_q       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // Idle stretch before the first redirect
    repeat (20) @(posedge clk);
    redirect(PC_BOOT, 5'd0);
    wait_entries(8);
    redirect(PC_JUMP, 5'd0);
    wait_entries(8);
    redirect(PC_BRANCH, 5'd0);
    wait_entries(8);
    dummy_en <= 1'b1;
    redirect(PC_MRET, 5'd0);
    wait_entries(12);
    redirect(PC_TRAP_EXC, 5'd0);
    wait_entries(12);
    redirect(PC_TRAP_IRQ, 5'd7);
    wait_entries(12);
    redirect(PC_TRAP_IRQ, 5'd31);
    wait_entries(12);
    hold_stage(12);
    wait_entries(6);
    kill_stage();
    wait_entries(8);
    // Crosses from normal memory into the error region
    targets.jump_target <= 32'h7fff_fff8;
    redirect(PC_JUMP, 5'd0);
    // Fillers here borrow the PC of an erroring word
    wait_entries(10);
    dummy_en <= 1'b0;
    // Back to back redirects while stale reads are in flight
    redirect(PC_BRANCH, 5'd0);
    redirect(PC_BOOT, 5'd0);
    wait_entries(6);
    repeat (10) @(posedge clk);
    errors = if_stage_inst.if_stage_asserts_inst.error_cnt;
    $display("Fetched %0d, dummies %0d, errors %0d", real_seen, dummy_seen, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/if_pkg.sv
rtl/prefetch_unit.sv
rtl/dummy_instr_gen.sv
rtl/if_issue.sv
rtl/if_stage.sv
sim/if_stage_asserts.sv
sim/tb_if_stage.sv

/* Makefile */
# Verilator build and run for the instruction fetch stage

VERILATOR ?= verilator
TOP       ?= tb_if_stage
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
